//--- vlog.f
+incdir+src
src/uart_rx_pkg.sv
src/uart_rx_frontend.sv
src/uart_receiver.sv
src/uart_rfifo.sv
src/uart_rx_top.sv
sim/uart_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the UART receive testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module uart_rx_tb -o uart_rx_sim \
	&& ./obj_dir/uart_rx_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^TB PASSED$' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/uart_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_tb;
	import uart_rx_pkg::*;

	localparam divisor_t DIVISOR = 16'd2;
	localparam int BIT_CLKS    = 16 * DIVISOR;  // clocks per serial bit
	localparam int FRAME_LIMIT = 16 * BIT_CLKS;  // longest wait for one record
	localparam int TOUT_CLKS   = 4 * 10 * BIT_CLKS;  // four 8N1 characters
	localparam int CYCLE_LIMIT = 60000;

	logic      clk;
	logic      wb_rst_i;
	logic      srx_pad_i;
	divisor_t  divisor_i;
	lcr_t      lcr_i;
	logic      rf_pop_i;
	logic      rx_reset_i;
	logic      lsr_mask_i;
	rx_rec_t   rf_data_o;
	fifo_cnt_t rf_count_o;
	logic      rf_overrun_o;
	logic      rf_error_o;
	logic      char_timeout_o;

	logic [15:0] lfsr;
	int          cycles = 0;
	rx_rec_t     expected_q [$];  // records of the 8N1 stream, oldest first

	uart_rx_top uut (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.srx_pad_i      (srx_pad_i),
		.divisor_i      (divisor_i),
		.lcr_i          (lcr_i),
		.rf_pop_i       (rf_pop_i),
		.rx_reset_i     (rx_reset_i),
		.lsr_mask_i     (lsr_mask_i),
		.rf_data_o      (rf_data_o),
		.rf_count_o     (rf_count_o),
		.rf_overrun_o   (rf_overrun_o),
		.rf_error_o     (rf_error_o),
		.char_timeout_o (char_timeout_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT)
			fail_run($sformatf("Timeout: run still going after %0d clocks", CYCLE_LIMIT));
	end

	// galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			b[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// {data, break, parity error, framing error}, data cut to the word length
	function automatic rx_rec_t make_record(input logic [7:0] data, input int nbits,
		input logic perr, input logic ferr);
		logic [7:0] mask;
		mask = 8'hFF >> (8 - nbits);
		return {data & mask, 1'b0, perr, ferr};
	endfunction

	task automatic send_bit(input logic b);
		@(negedge clk);
		srx_pad_i = b;
		repeat (BIT_CLKS - 1) @(negedge clk);
	endtask

	task automatic send_frame(input logic [7:0] data, input int nbits, input logic par_en,
		input logic par_bit, input logic stop_lvl);
		send_bit(1'b0);  // start
		for (int i = 0; i < nbits; i++)
			send_bit(data[i]);
		if (par_en)
			send_bit(par_bit);
		send_bit(stop_lvl);
	endtask

	task automatic wait_count(input int n, input int limit);
		int waited;
		waited = 0;
		while (rf_count_o != n)
		begin
			@(negedge clk);
			waited++;
			if (waited > limit)
				fail_run($sformatf("FIFO count did not reach %0d within %0d clocks", n, limit));
		end
	endtask

	task automatic check_head(input rx_rec_t exp, input string what);
		assert (rf_count_o != 0 && rf_data_o === exp)
		else
			fail_run($sformatf("Error at %0t: %s record %h, expected %h",
				$time, what, rf_data_o, exp));
	endtask

	task automatic pop_head();
		@(negedge clk);
		rf_pop_i = 1'b1;
		@(negedge clk);
		rf_pop_i = 1'b0;
	endtask

	task automatic test_8n1_stream();
		logic [7:0] b;
		lcr_i = 8'h03;
		for (int i = 0; i < 8; i++)
		begin
			random_byte(b);
			expected_q.push_back(make_record(b, 8, 1'b0, 1'b0));
			send_frame(b, 8, 1'b0, 1'b0, 1'b1);
		end
		wait_count(8, FRAME_LIMIT);
		while (expected_q.size() > 0)
		begin
			check_head(expected_q.pop_front(), "8N1");
			pop_head();
		end
	endtask

	task automatic test_word_lengths();
		logic [7:0] b;
		for (int n = 5; n < 8; n++)
		begin
			lcr_i = lcr_t'(n - 5);
			random_byte(b);
			send_frame(b, n, 1'b0, 1'b0, 1'b1);
			wait_count(1, FRAME_LIMIT);
			check_head(make_record(b, n, 1'b0, 1'b0), "word length");
			pop_head();
		end
	endtask

	task automatic parity_case(input lcr_t lcr, input logic wrong, input string what);
		logic [7:0] b;
		logic       par;
		lcr_i = lcr;
		random_byte(b);
		if (lcr[`UART_LC_SP])
			par = !lcr[`UART_LC_EP];  // stick: 1 with EP clear, 0 with EP set
		else if (lcr[`UART_LC_EP])
			par = ^b;
		else
			par = ~^b;
		send_frame(b, 8, 1'b1, par ^ wrong, 1'b1);
		wait_count(1, FRAME_LIMIT);
		check_head(make_record(b, 8, wrong, 1'b0), what);
		assert (rf_error_o === wrong)
		else
			fail_run($sformatf("Error at %0t: %s error-in-FIFO %b, expected %b",
				$time, what, rf_error_o, wrong));
		pop_head();
	endtask

	task automatic test_framing_break();
		logic [7:0] b;
		lcr_i = 8'h03;
		random_byte(b);
		b[0] = 1'b1;  // keeps the low run shorter than a break
		send_frame(b, 8, 1'b0, 1'b0, 1'b0);
		send_bit(1'b1);
		wait_count(1, FRAME_LIMIT);
		check_head(make_record(b, 8, 1'b0, 1'b1), "framing");
		pop_head();
		repeat (20) send_bit(1'b0);  // two character times low
		repeat (2) send_bit(1'b1);
		wait_count(1, FRAME_LIMIT);
		check_head({8'h00, 1'b1, 1'b0, 1'b0}, "break");
		pop_head();
	endtask

	task automatic test_overrun();
		logic [7:0] b;
		lcr_i = 8'h03;
		for (int i = 0; i <= `UART_FIFO_DEPTH; i++)
		begin
			random_byte(b);
			send_frame(b, 8, 1'b0, 1'b0, 1'b1);
			if (i == `UART_FIFO_DEPTH - 1)
				assert (!rf_overrun_o && rf_count_o == `UART_FIFO_DEPTH)
				else
					fail_run($sformatf("Error at %0t: full FIFO count %0d overrun %b",
						$time, rf_count_o, rf_overrun_o));
		end
		send_bit(1'b1);
		assert (rf_overrun_o && rf_count_o == `UART_FIFO_DEPTH)
		else
			fail_run($sformatf("Error at %0t: after extra frame count %0d overrun %b",
				$time, rf_count_o, rf_overrun_o));
		lsr_mask_i = 1'b1;
		@(negedge clk);
		lsr_mask_i = 1'b0;
		assert (!rf_overrun_o && rf_count_o == `UART_FIFO_DEPTH)
		else
			fail_run($sformatf("Error at %0t: overrun %b after status clear", $time, rf_overrun_o));
		rx_reset_i = 1'b1;
		@(negedge clk);
		rx_reset_i = 1'b0;
		assert (rf_count_o == 0)
		else
			fail_run($sformatf("Error at %0t: count %0d after FIFO reset", $time, rf_count_o));
	endtask

	task automatic test_char_timeout();
		logic [7:0] b;
		int         waited;
		lcr_i = 8'h03;
		random_byte(b);
		send_frame(b, 8, 1'b0, 1'b0, 1'b1);
		wait_count(1, FRAME_LIMIT);
		waited = 0;
		while (!char_timeout_o)
		begin
			@(negedge clk);
			waited++;
			if (waited > TOUT_CLKS + 4 * BIT_CLKS)
				fail_run("Character timeout did not rise with one character left in the FIFO");
		end
		assert (waited >= TOUT_CLKS - 2 * BIT_CLKS)
		else
			fail_run($sformatf("Error at %0t: timeout after only %0d clocks", $time, waited));
		pop_head();
		assert (!char_timeout_o && rf_count_o == 0)
		else
			fail_run($sformatf("Error at %0t: timeout %b after pop", $time, char_timeout_o));
	endtask

	initial
	begin
		wb_rst_i   = 1'b1;
		srx_pad_i  = 1'b1;  // idle line
		divisor_i  = DIVISOR;
		lcr_i      = 8'h03;
		rf_pop_i   = 1'b0;
		rx_reset_i = 1'b0;
		lsr_mask_i = 1'b0;
		lfsr       = 16'd420;
		repeat (2) @(posedge clk);
		@(negedge clk);
		wb_rst_i = 1'b0;
		send_bit(1'b1);
		test_8n1_stream();
		test_word_lengths();
		parity_case(8'h1B, 1'b0, "even parity");
		parity_case(8'h0B, 1'b0, "odd parity");
		parity_case(8'h1B, 1'b1, "wrong even parity");
		parity_case(8'h2B, 1'b0, "stick parity 1");
		parity_case(8'h3B, 1'b0, "stick parity 0");
		parity_case(8'h2B, 1'b1, "wrong stick parity");
		test_framing_break();
		test_overrun();
		test_char_timeout();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/uart_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_top (
	input  logic                   clk,
	input  logic                   wb_rst_i,
	input  logic                   srx_pad_i,
	input  uart_rx_pkg::divisor_t  divisor_i,
	input  uart_rx_pkg::lcr_t      lcr_i,
	input  logic                   rf_pop_i,
	input  logic                   rx_reset_i,
	input  logic                   lsr_mask_i,
	output uart_rx_pkg::rx_rec_t   rf_data_o,
	output uart_rx_pkg::fifo_cnt_t rf_count_o,
	output logic                   rf_overrun_o,
	output logic                   rf_error_o,
	output logic                   char_timeout_o
);
	import uart_rx_pkg::*;

	logic    enable;
	logic    srx_sync;
	logic    rf_push_pulse;
	rx_rec_t rf_data_in;

	uart_rx_frontend u_frontend (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.divisor_i (divisor_i),
		.srx_pad_i (srx_pad_i),
		.enable_o  (enable),
		.srx_o     (srx_sync)
	);

	uart_receiver u_receiver (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.lcr_i          (lcr_i),
		.enable_i       (enable),
		.srx_i          (srx_sync),
		.rf_pop_i       (rf_pop_i),
		.rf_count_i     (rf_count_o),  // restarts the timeout while empty
		.rf_data_o      (rf_data_in),
		.rf_push_o      (rf_push_pulse),
		.char_timeout_o (char_timeout_o)
	);

	uart_rfifo #(
		.DEPTH (`UART_FIFO_DEPTH)
	) u_rfifo (
		.clk            (clk),
		.wb_rst_i       (wb_rst_i),
		.fifo_reset_i   (rx_reset_i),
		.reset_status_i (lsr_mask_i),
		.push_i         (rf_push_pulse),
		.pop_i          (rf_pop_i),
		.data_i         (rf_data_in),
		.data_o         (rf_data_o),
		.count_o        (rf_count_o),
		.overrun_o      (rf_overrun_o),
		.error_o        (rf_error_o)
	);

endmodule

`default_nettype wire

//--- src/uart_rfifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rfifo #(
	parameter int DEPTH = `UART_FIFO_DEPTH
) (
	input  logic                   clk,
	input  logic                   wb_rst_i,
	input  logic                   fifo_reset_i,    // drops all entries
	input  logic                   reset_status_i,  // clears overrun
	input  logic                   push_i,
	input  logic                   pop_i,
	input  uart_rx_pkg::rx_rec_t   data_i,
	output uart_rx_pkg::rx_rec_t   data_o,  // head record
	output uart_rx_pkg::fifo_cnt_t count_o,
	output logic                   overrun_o,
	output logic                   error_o
);
	import uart_rx_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
	localparam fifo_cnt_t CNT_FULL = fifo_cnt_t'(DEPTH);

	rx_rec_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_next;
	logic [PTR_W-1:0] rd_ptr_next;
	logic [DEPTH-1:0] err_q;  // one per entry, any of the three flags
	logic             empty;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign empty   = (count_o == '0);
	assign full    = (count_o == CNT_FULL);
	assign do_pop  = pop_i && !empty;
	assign do_push = push_i && (!full || do_pop);  // full push is lost

	assign wr_ptr_next = (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
	assign rd_ptr_next = (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
			err_q   <= '0;
		end
		else if (fifo_reset_i)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
			err_q   <= '0;
		end
		else
		begin
			if (do_pop)
			begin
				rd_ptr        <= rd_ptr_next;
				err_q[rd_ptr] <= 1'b0;
			end
			if (do_push)  // after the pop, so a reused slot keeps the new flag
			begin
				wr_ptr        <= wr_ptr_next;
				err_q[wr_ptr] <= |data_i[2:0];
			end
			if (do_push && !do_pop)
				count_o <= count_o + 1'b1;
			else if (do_pop && !do_push)
				count_o <= count_o - 1'b1;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			overrun_o <= 1'b0;
		else if (fifo_reset_i || reset_status_i)
			overrun_o <= 1'b0;
		else if (push_i && full && !do_pop)
			overrun_o <= 1'b1;
	end

	assign error_o = |err_q;

	a_count_bound: assert property (@(posedge clk) disable iff (wb_rst_i)
		count_o <= CNT_FULL)
		else $error("FIFO count above depth");

endmodule

`default_nettype wire

//--- src/uart_receiver.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_receiver (
	input  logic                   clk,
	input  logic                   wb_rst_i,
	input  uart_rx_pkg::lcr_t      lcr_i,
	input  logic                   enable_i,  // 16x bit-rate tick
	input  logic                   srx_i,     // synchronised serial line
	input  logic                   rf_pop_i,
	input  uart_rx_pkg::fifo_cnt_t rf_count_i,
	output uart_rx_pkg::rx_rec_t   rf_data_o,
	output logic                   rf_push_o,
	output logic                   char_timeout_o
);
	import uart_rx_pkg::*;

	rx_state_e  rstate;
	logic [3:0] rcounter16;  // ticks left in the current bit
	logic [3:0] rcounter16_minus_1;
	logic       rcounter16_eq_7;
	logic       rcounter16_eq_0;
	logic [2:0] rbit_counter;  // data bits still to come
	logic [7:0] rshift;
	logic       rparity;
	logic       rparity_xor;
	logic       rparity_error;
	logic       rframing_error;
	logic       rf_push;  // push level, held until the next tick
	logic       rf_push_q;
	rx_rec_t    rf_data_in;
	toc_t       toc_value;
	toc_t       counter_t;
	brc_t       brc_value;
	brc_t       counter_b;  // counts low ticks on the line
	logic       break_error;

	assign rcounter16_minus_1 = rcounter16 - 1'b1;
	assign rcounter16_eq_7    = (rcounter16 == 4'd7);
	assign rcounter16_eq_0    = (rcounter16 == 4'd0);
	assign break_error        = (counter_b == '0);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			rstate         <= idle;
			rcounter16     <= '0;
			rbit_counter   <= '0;
			rshift         <= '0;
			rparity        <= 1'b0;
			rparity_xor    <= 1'b0;
			rparity_error  <= 1'b0;
			rframing_error <= 1'b0;
			rf_push        <= 1'b0;
			rf_data_in     <= '0;
		end
		else if (enable_i)
		begin
			case (rstate)
				idle:
				begin
					rf_push    <= 1'b0;
					rf_data_in <= '0;
					rcounter16 <= 4'b1110;
					if (!srx_i && !break_error)  // falling edge, maybe a start bit
						rstate <= rec_start;
				end
				rec_start:
				begin
					rf_push <= 1'b0;
					if (rcounter16_eq_7)
					begin
						if (srx_i)
							rstate <= idle;  // glitch, line back high
						else
							rstate <= rec_prepare;
					end
					rcounter16 <= rcounter16_minus_1;
				end
				rec_prepare:
				begin
					rbit_counter <= {1'b1, lcr_i[1:0]};  // 4 to 7 for 5 to 8 bits
					if (rcounter16_eq_0)
					begin
						rstate <= rec_bit;
						rshift <= '0;
					end
					rcounter16 <= rcounter16_minus_1;
				end
				rec_bit:
				begin
					if (rcounter16_eq_0)
						rstate <= end_bit;
					if (rcounter16_eq_7)  // mid-bit sample, shifted in from the top
					begin
						case (lcr_i[1:0])
							2'b00: rshift[4:0] <= {srx_i, rshift[4:1]};
							2'b01: rshift[5:0] <= {srx_i, rshift[5:1]};
							2'b10: rshift[6:0] <= {srx_i, rshift[6:1]};
							default: rshift <= {srx_i, rshift[7:1]};
						endcase
					end
					rcounter16 <= rcounter16_minus_1;
				end
				end_bit:
				begin
					if (rbit_counter == '0)
					begin
						if (lcr_i[`UART_LC_PE])
							rstate <= rec_parity;
						else
						begin
							rstate        <= rec_stop;
							rparity_error <= 1'b0;
						end
					end
					else
					begin
						rstate       <= rec_bit;
						rbit_counter <= rbit_counter - 1'b1;
					end
					rcounter16 <= 4'b1110;
				end
				rec_parity:
				begin
					if (rcounter16_eq_7)
					begin
						rparity <= srx_i;
						rstate  <= ca_lc_parity;
					end
					rcounter16 <= rcounter16_minus_1;
				end
				ca_lc_parity:
				begin
					rparity_xor <= ^{rshift, rparity};  // unused upper bits are zero
					rstate      <= check_parity;
					rcounter16  <= rcounter16_minus_1;
				end
				check_parity:
				begin
					case ({lcr_i[`UART_LC_EP], lcr_i[`UART_LC_SP]})
						2'b00: rparity_error <= (rparity_xor == 1'b0);  // odd
						2'b01: rparity_error <= !rparity;  // stuck at 1
						2'b10: rparity_error <= (rparity_xor == 1'b1);  // even
						default: rparity_error <= rparity;  // stuck at 0
					endcase
					rstate     <= wait1;
					rcounter16 <= rcounter16_minus_1;
				end
				wait1:
				begin
					if (rcounter16_eq_0)
					begin
						rstate     <= rec_stop;
						rcounter16 <= 4'b1110;
					end
					else
						rcounter16 <= rcounter16_minus_1;
				end
				rec_stop:
				begin
					if (rcounter16_eq_7)
					begin
						rframing_error <= !srx_i;  // stop bit must be high
						rstate         <= push;
					end
					rcounter16 <= rcounter16_minus_1;
				end
				push:
				begin
					if (srx_i || break_error)
					begin
						if (break_error)
							rf_data_in <= {8'b0, 3'b100};  // empty character with break
						else
							rf_data_in <= {rshift, 1'b0, rparity_error, rframing_error};
						rf_push <= 1'b1;
						rstate  <= idle;
					end
					else if (!rframing_error)  // next start bit follows directly
					begin
						rf_data_in <= {rshift, 1'b0, rparity_error, rframing_error};
						rf_push    <= 1'b1;
						rcounter16 <= 4'b1110;
						rstate     <= rec_start;
					end
					// low line after a framing error: hold until break or idle
				end
				default: rstate <= idle;
			endcase
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			rf_push_q <= 1'b0;
		else
			rf_push_q <= rf_push;
	end

	assign rf_push_o = rf_push && !rf_push_q;
	assign rf_data_o = rf_data_in;

	// four character times in ticks, from word length, stop bits and parity
	always_comb
	begin
		case (lcr_i[3:0])
			4'b0000: toc_value = 10'd447;  // 7 bits
			4'b0100: toc_value = 10'd479;  // 7.5 bits
			4'b0001, 4'b1000: toc_value = 10'd511;  // 8 bits
			4'b1100: toc_value = 10'd543;  // 8.5 bits
			4'b0010, 4'b0101, 4'b1001: toc_value = 10'd575;  // 9 bits
			4'b0011, 4'b0110, 4'b1010, 4'b1101: toc_value = 10'd639;  // 10 bits
			4'b0111, 4'b1011, 4'b1110: toc_value = 10'd703;  // 11 bits
			default: toc_value = 10'd767;  // 12 bits
		endcase
	end

	assign brc_value = toc_value[9:2];  // one character time

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			counter_b <= 8'd159;
		else if (srx_i)
			counter_b <= brc_value;
		else if (enable_i && counter_b != '0)
			counter_b <= counter_b - 1'b1;
	end

	// restarts on any FIFO access and while the FIFO is empty
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			counter_t <= 10'd639;  // 8N1
		else if (rf_push_o || rf_pop_i || rf_count_i == '0)
			counter_t <= toc_value;
		else if (enable_i && counter_t != '0)
			counter_t <= counter_t - 1'b1;
	end

	assign char_timeout_o = (counter_t == '0) && (rf_count_i != '0);

	// push level must drop before the next character is assembled
	a_push_released: assert property (@(posedge clk) disable iff (wb_rst_i)
		rf_push |-> (rstate == idle || rstate == rec_start))
		else $error("push level still high while a character is received");

endmodule

`default_nettype wire

//--- src/uart_rx_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frontend (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  uart_rx_pkg::divisor_t divisor_i,
	input  logic                  srx_pad_i,
	output logic                  enable_o,  // one tick per 1/16 bit
	output logic                  srx_o
);
	import uart_rx_pkg::*;

	divisor_t dlc;  // clocks left until the next tick
	logic     srx_meta;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			dlc      <= '0;
			enable_o <= 1'b0;
		end
		else
		begin
			if (divisor_i == '0)
				dlc <= '0;  // parked while the divisor is unset
			else if (dlc == '0)
				dlc <= divisor_i - 1'b1;
			else
				dlc <= dlc - 1'b1;
			enable_o <= (dlc == '0) && (divisor_i != '0);
		end
	end

	// two flops on the pad, idle line is high
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			srx_meta <= 1'b1;
			srx_o    <= 1'b1;
		end
		else
		begin
			srx_meta <= srx_pad_i;
			srx_o    <= srx_meta;
		end
	end

	a_enable_spaced: assert property (@(posedge clk) disable iff (wb_rst_i)
		(enable_o && divisor_i > 16'd1 && $stable(divisor_i)) |=> !enable_o)
		else $error("enable tick high on consecutive cycles");

endmodule

`default_nettype wire

//--- src/uart_rx_pkg.sv
`default_nettype none

`include "uart_rx_macros.svh"

package uart_rx_pkg;

	// line control word; 1:0 word length, 2 stop bits, 3 PE, 4 EP, 5 SP
	typedef logic [7:0] lcr_t;

	typedef logic [15:0] divisor_t;  // clocks per 16x tick

	// {data[7:0], break, parity error, framing error}
	typedef logic [`UART_FIFO_REC_WIDTH-1:0] rx_rec_t;

	typedef logic [`UART_FIFO_COUNTER_W-1:0] fifo_cnt_t;

	typedef logic [9:0] toc_t;  // character timeout in ticks
	typedef logic [7:0] brc_t;  // break length in ticks

	typedef enum logic [3:0] {
		idle         = 4'd0,
		rec_start    = 4'd1,
		rec_bit      = 4'd2,
		rec_parity   = 4'd3,
		rec_stop     = 4'd4,
		check_parity = 4'd5,
		rec_prepare  = 4'd6,
		end_bit      = 4'd7,
		ca_lc_parity = 4'd8,
		wait1        = 4'd9,
		push         = 4'd10
	} rx_state_e;

endpackage

`default_nettype wire

//--- src/uart_rx_macros.svh
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// receive FIFO geometry
`define UART_FIFO_DEPTH 16
`define UART_FIFO_COUNTER_W 5

// one record is 8 data bits plus break, parity and framing flags
`define UART_FIFO_REC_WIDTH 11

// line control register bits
`define UART_LC_PE 3  // parity enable
`define UART_LC_EP 4  // even parity
`define UART_LC_SP 5  // stick parity

`endif
